//--- hdl/rx_pkg.sv
//******************************
// Receive path package
// Word width limits, word beat type and lock constants
// shared by the deserializer, aligner and capture stages
//******************************

package rx_pkg;

    //******************************
    // Width limits
    //******************************

    localparam int max_width = 10;                 // Widest supported word
    localparam int min_width = 3;                  // Narrowest supported word

    // Word container, sized for the widest word
    // Only the low WIDTH bits carry data, the rest read zero
    typedef logic [max_width-1:0] rx_word_t;

    //******************************
    // Word beat
    //******************************

    // One word boundary event from the deserializer
    typedef struct packed {
        rx_word_t data;                            // Framed word, MSB first in time
        logic     valid;                           // One-cycle boundary strobe
    } word_beat_t;

    //******************************
    // Lock constants
    //******************************

    localparam int lock_matches = 4;               // Consecutive training hits for lock
    localparam int match_cnt_w  = $clog2(lock_matches + 1); // Match counter width

endpackage : rx_pkg

//--- hdl/serial_deserializer.sv
//******************************
// Serial deserializer
// Frames one serial bit per cycle into WIDTH-bit words
// and stretches a frame by one bit on a slip request
//******************************

module serial_deserializer #(
    parameter int WIDTH = 8                        // Word width, 3 to 10
) (
    input  logic               fabric_clk_div,     // Bit rate clock
    input  logic               reset_buf_n,        // Async reset, active low
    input  logic               enable_n,           // Active-low enable
    input  logic               serial_in,          // Serial data in
    input  logic               slip,               // Slip strobe from aligner
    output rx_pkg::word_beat_t beat                // Framed word beat
);
    import rx_pkg::*;

    localparam int cnt_w = $clog2(max_width);      // Bit counter width
    localparam logic [cnt_w-1:0] last_bit = cnt_w'(WIDTH - 1); // Final bit of a frame
    localparam rx_word_t word_mask = {max_width{1'b1}} >> (max_width - WIDTH);

    rx_word_t         shift_q;                     // Shift register, newest bit in LSB
    rx_word_t         shift_next;                  // Shift register after this bit
    logic [cnt_w-1:0] bit_cnt;                     // Position within current frame
    logic             slip_pend;                   // Slip waiting for frame end
    logic             slip_seen;                   // Pending or arriving slip
    logic             frame_end;                   // Last bit of frame this cycle
    logic             emit;                        // Frame completes without slip
    rx_word_t         beat_data_q;                 // Registered framed word
    logic             beat_valid_q;                // Registered boundary strobe

    assign shift_next = {shift_q[max_width-2:0], serial_in}; // First bit ends up as MSB
    assign slip_seen  = slip_pend | slip;
    assign frame_end  = (bit_cnt == last_bit);
    assign emit       = !enable_n && frame_end && !slip_seen;

    //******************************
    // Data path
    //******************************

    always_ff @(posedge fabric_clk_div) begin
        if (!enable_n) begin
            shift_q <= shift_next;                 // One bit per cycle
        end
    end

    always_ff @(posedge fabric_clk_div) begin
        if (emit) begin
            beat_data_q <= shift_next & word_mask; // Clear bits above WIDTH
        end
    end

    //******************************
    // Framing control
    //******************************

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt      <= '0;
            slip_pend    <= 1'b0;
            beat_valid_q <= 1'b0;
        end else if (enable_n) begin
            bit_cnt      <= '0;                    // Restart framing when re-enabled
            slip_pend    <= 1'b0;
            beat_valid_q <= 1'b0;
        end else begin
            beat_valid_q <= emit;
            if (frame_end) begin
                slip_pend <= 1'b0;                 // Slip consumed here or none pending
                if (!slip_seen) begin
                    bit_cnt <= '0;                 // Next frame starts
                end                                // Else hold, frame takes one more bit
            end else begin
                bit_cnt   <= bit_cnt + 1'b1;
                slip_pend <= slip_seen;            // Keep slip until frame end
            end
        end
    end

    assign beat = '{data: beat_data_q, valid: beat_valid_q};

endmodule : serial_deserializer

//--- hdl/word_aligner.sv
//******************************
// Word aligner
// Searches for the training word, slips until it lines up,
// locks after repeated hits and gates ready on startup settle
//******************************

module word_aligner #(
    parameter int                WIDTH         = 8,   // Word width, 3 to 10
    parameter rx_pkg::rx_word_t  TRAIN_PATTERN = rx_pkg::rx_word_t'(8'h6a), // Training word
    parameter int                SETTLE_CYCLES = 255  // Startup wait in cycles
) (
    input  logic               fabric_clk_div,     // Bit rate clock
    input  logic               reset_buf_n,        // Async reset, active low
    input  logic               enable_n,           // Active-low enable
    input  logic               bitslip_n,          // Manual slip, active low
    input  rx_pkg::word_beat_t beat,               // Word beat from deserializer
    output logic               slip,               // Slip strobe to deserializer
    output logic               ready               // Settled and locked
);
    import rx_pkg::*;

    localparam rx_word_t word_mask = {max_width{1'b1}} >> (max_width - WIDTH);
    localparam rx_word_t train_word = TRAIN_PATTERN & word_mask; // Compared bits only
    localparam int settle_w = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES + 1) : 1;
    localparam logic [settle_w-1:0] settle_last = settle_w'(SETTLE_CYCLES);
    localparam logic [match_cnt_w-1:0] match_last = match_cnt_w'(lock_matches - 1);

    typedef enum logic [1:0] {
        st_search,                                 // Checking every beat
        st_skip,                                   // Beat after a slip is ignored
        st_locked                                  // Boundary found
    } state_t;

    state_t                 state;                 // Search FSM state
    logic [match_cnt_w-1:0] match_cnt;             // Consecutive training hits
    logic [settle_w-1:0]    settle_cnt;            // Startup wait counter
    logic                   beat_match;            // Beat equals training word
    logic                   auto_slip;             // Mismatch during search
    logic                   settled;               // Startup wait complete

    assign beat_match = ((beat.data & word_mask) == train_word);
    assign auto_slip  = !enable_n && beat.valid && (state == st_search) && !beat_match;

    //******************************
    // Search FSM
    //******************************

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            state     <= st_search;
            match_cnt <= '0;
        end else if (enable_n) begin
            state     <= st_search;                // Disable drops lock
            match_cnt <= '0;
        end else if (beat.valid) begin
            case (state)
                st_search: begin
                    if (beat_match) begin
                        match_cnt <= match_cnt + 1'b1;
                        if (match_cnt == match_last) begin
                            state <= st_locked;    // Enough hits in a row
                        end
                    end else begin
                        match_cnt <= '0;           // Run broken, slip and retry
                        state     <= st_skip;
                    end
                end
                st_skip: begin
                    state <= st_search;            // Drop beat framed across the slip
                end
                default: begin
                    state <= st_locked;            // Lock holds until disable or reset
                end
            endcase
        end
    end

    //******************************
    // Slip merge
    //******************************

    // Automatic and manual requests share one strobe
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            slip <= 1'b0;
        end else begin
            slip <= auto_slip || !bitslip_n;       // Manual slip in any state
        end
    end

    //******************************
    // Startup settle
    //******************************

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            settle_cnt <= '0;
        end else if (settle_cnt != settle_last) begin
            settle_cnt <= settle_cnt + 1'b1;       // Saturates at SETTLE_CYCLES
        end
    end

    assign settled = (settle_cnt == settle_last);
    assign ready   = settled && (state == st_locked);

endmodule : word_aligner

//--- hdl/rx_word_capture.sv
//******************************
// Word capture
// Registers aligned words while ready and strobes them out
//******************************

module rx_word_capture #(
    parameter int WIDTH = 8                        // Word width, 3 to 10
) (
    input  logic               fabric_clk_div,     // Bit rate clock
    input  logic               reset_buf_n,        // Async reset, active low
    input  rx_pkg::word_beat_t beat,               // Word beat from deserializer
    input  logic               ready,              // Alignment ready
    output rx_pkg::rx_word_t   data,               // Captured word
    output logic               data_strobe         // One cycle per new word
);
    import rx_pkg::*;

    localparam rx_word_t word_mask = {max_width{1'b1}} >> (max_width - WIDTH);

    logic take;                                    // Beat accepted this cycle

    // Words before ready are dropped, no back-pressure
    assign take = beat.valid && ready;

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            data        <= '0;
            data_strobe <= 1'b0;
        end else begin
            data_strobe <= take;                   // Pulse with each new word
            if (take) begin
                data <= beat.data & word_mask;     // Upper bits forced to zero
            end                                    // Else hold last word
        end
    end

endmodule : rx_word_capture

//--- hdl/serial_rx_top.sv
//******************************
// Serial receive top level
// Deserializer, word aligner and capture stage,
// two cycles from last serial bit to data strobe
//******************************

module serial_rx_top #(
    parameter int               WIDTH         = 8,    // Word width, 3 to 10
    parameter rx_pkg::rx_word_t TRAIN_PATTERN = rx_pkg::rx_word_t'(8'h6a), // Training word
    parameter int               SETTLE_CYCLES = 255   // Startup wait in cycles
) (
    input  logic             fabric_clk_div,       // Bit rate clock
    input  logic             reset_buf_n,          // Async reset, active low
    input  logic             enable_n,             // Active-low enable
    input  logic             serial_in,            // Serial data, one bit per cycle
    input  logic             bitslip_n,            // Manual slip, active low
    output rx_pkg::rx_word_t data,                 // Captured word
    output logic             data_strobe,          // Strobe for data
    output logic             ready                 // Settled and locked
);
    import rx_pkg::*;

    word_beat_t beat;                              // Framed word beat
    logic       slip;                              // Slip strobe back to deserializer

    //******************************
    // Framing
    //******************************

    serial_deserializer #(
        .WIDTH          (WIDTH)
    ) serial_deserializer_inst (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .enable_n       (enable_n),
        .serial_in      (serial_in),
        .slip           (slip),
        .beat           (beat)
    );

    //******************************
    // Alignment and readiness
    //******************************

    word_aligner #(
        .WIDTH          (WIDTH),
        .TRAIN_PATTERN  (TRAIN_PATTERN),
        .SETTLE_CYCLES  (SETTLE_CYCLES)
    ) word_aligner_inst (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .enable_n       (enable_n),
        .bitslip_n      (bitslip_n),
        .beat           (beat),
        .slip           (slip),
        .ready          (ready)
    );

    // Output register stage
    rx_word_capture #(
        .WIDTH          (WIDTH)
    ) rx_word_capture_inst (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .beat           (beat),
        .ready          (ready),
        .data           (data),
        .data_strobe    (data_strobe)
    );

endmodule : serial_rx_top

//--- test/tb_serial_rx.sv
//******************************
// Serial receive testbench
// Streams framed serial words into the receive top level
// and checks lock, payload order, bit slip and relock
//******************************

module tb_serial_rx;
    import rx_pkg::*;

    localparam int       width         = 8;                    // DUT word width
    localparam rx_word_t train_word    = rx_word_t'(8'h6a);    // Training word
    localparam int       settle_cycles = 255;                  // DUT startup wait
    localparam rx_word_t word_mask     = rx_word_t'((1 << width) - 1);
    localparam int       wait_limit    = 200;                  // Cycles per capture wait
    localparam int       lock_limit    = settle_cycles + 600;  // Cycles to reach ready

    logic        fabric_clk_div;
    logic        reset_buf_n;
    logic        enable_n;
    logic        serial_in;
    logic        bitslip_n;
    rx_word_t    data;
    logic        data_strobe;
    logic        ready;

    logic        bit_q[$];                         // Bits waiting for the line
    rx_word_t    cap_q[$];                         // Words seen with data_strobe
    logic        stream_on;                        // Line carries words when set
    logic [31:0] rng_state;                        // Xorshift state

    serial_rx_top #(
        .WIDTH          (width),
        .TRAIN_PATTERN  (train_word),
        .SETTLE_CYCLES  (settle_cycles)
    ) serial_rx_top_inst (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .enable_n       (enable_n),
        .serial_in      (serial_in),
        .bitslip_n      (bitslip_n),
        .data           (data),
        .data_strobe    (data_strobe),
        .ready          (ready)
    );

    initial begin
        fabric_clk_div = 1'b0;
        forever begin
            #5 fabric_clk_div = ~fabric_clk_div;   // Period 10
        end
    end

    //******************************
    // Helpers
    //******************************

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_word(input rx_word_t actual, input rx_word_t expected,
                              input string what);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: time %0t: %s expected %h, got %h",
                                $time, what, expected, actual));
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: time %0t: %s expected %b, got %b",
                                $time, what, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Random word that never looks like the training word
    function automatic rx_word_t next_payload();
        rx_word_t w;
        w = rx_word_t'(xorshift32()) & word_mask;
        while (w == train_word) begin
            w = rx_word_t'(xorshift32()) & word_mask;
        end
        return w;
    endfunction

    // Word framed one bit late, low bits of a then MSB of b
    function automatic rx_word_t slipped_word(input rx_word_t a, input rx_word_t b);
        return ((a << 1) | (b >> (width - 1))) & word_mask;
    endfunction

    task automatic queue_word(input rx_word_t w);
        int i;
        for (i = width - 1; i >= 0; i--) begin
            bit_q.push_back(w[i]);                 // MSB goes out first
        end
    endtask

    task automatic queue_junk(input int count);
        logic [31:0] r;
        int          i;
        for (i = 0; i < count; i++) begin
            r = xorshift32();
            bit_q.push_back(r[0]);                 // Shifts the word boundary
        end
    endtask

    // Line driver, training words fill any gap
    task automatic drive_serial();
        logic b;
        forever begin
            @(posedge fabric_clk_div);
            if (stream_on) begin
                if (bit_q.size() == 0) begin
                    queue_word(train_word);
                end
                b = bit_q.pop_front();
                serial_in <= b;
            end else begin
                serial_in <= 1'b0;
            end
        end
    endtask

    task automatic watch_strobes();
        forever begin
            @(negedge fabric_clk_div);
            if (data_strobe === 1'b1) begin
                cap_q.push_back(data);
            end
        end
    endtask

    task automatic wait_capture(output rx_word_t word);
        int waited;
        waited = 0;
        while (cap_q.size() == 0) begin
            if (waited >= wait_limit) begin
                abort_run("No data strobe arrived within the capture timeout");
            end
            @(negedge fabric_clk_div);
            waited++;
        end
        word = cap_q.pop_front();
    endtask

    task automatic skip_training(output rx_word_t word);
        int skipped;
        skipped = 0;
        wait_capture(word);
        while (word == train_word) begin
            if (skipped >= 8) begin
                abort_run("Captured words stayed on the training word, payload never arrived");
            end
            wait_capture(word);
            skipped++;
        end
    endtask

    task automatic wait_ready(input int limit, output int waited);
        waited = 0;
        while (ready !== 1'b1) begin
            if (waited >= limit) begin
                abort_run("ready did not rise within the lock timeout");
            end
            @(negedge fabric_clk_div);
            waited++;
        end
    endtask

    task automatic apply_reset(input int junk_bits);
        @(posedge fabric_clk_div);
        reset_buf_n <= 1'b0;
        repeat (16) @(posedge fabric_clk_div);
        @(negedge fabric_clk_div);
        bit_q.delete();
        cap_q.delete();
        queue_junk(junk_bits);                     // Offset before training
        stream_on = 1'b1;
        @(posedge fabric_clk_div);
        reset_buf_n <= 1'b1;
    endtask

    //******************************
    // Directed tests
    //******************************

    task automatic test_reset_idle();
        int i;
        for (i = 0; i < 16; i++) begin
            @(negedge fabric_clk_div);
            check_bit(ready, 1'b0, "ready in reset");
            check_word(data, '0, "data in reset");
            check_bit(data_strobe, 1'b0, "data_strobe in reset");
        end
        @(posedge fabric_clk_div);
        reset_buf_n <= 1'b1;
        for (i = 0; i < 100; i++) begin
            @(negedge fabric_clk_div);
            check_bit(ready, 1'b0, "ready while idle");
            check_word(data, '0, "data while idle");
            check_bit(data_strobe, 1'b0, "data_strobe while idle");
        end
    endtask

    task automatic test_lock_with_offset();
        int offsets[3];
        int i;
        int waited;
        offsets = '{0, 3, 7};
        for (i = 0; i < 3; i++) begin
            apply_reset(offsets[i]);
            wait_ready(lock_limit, waited);
            check_bit(waited >= settle_cycles, 1'b1, "ready held off for the settle time");
        end
    endtask

    task automatic test_payload_in_order();
        rx_word_t sent[$];
        rx_word_t w;
        int       i;
        @(negedge fabric_clk_div);
        cap_q.delete();
        queue_word(train_word);
        queue_word(train_word);
        for (i = 0; i < 32; i++) begin
            w = next_payload();
            sent.push_back(w);
            queue_word(w);
        end
        skip_training(w);
        for (i = 0; i < 32; i++) begin
            if (i > 0) begin
                wait_capture(w);
            end
            check_word(w, sent[i], "payload word");
            check_bit(ready, 1'b1, "ready during payload");
        end
    endtask

    task automatic test_manual_bitslip();
        rx_word_t sent[$];
        rx_word_t w;
        int       i;
        int       m;
        int       tries;
        logic     found;
        @(negedge fabric_clk_div);
        cap_q.delete();
        for (i = 0; i < 40; i++) begin
            w = next_payload();
            sent.push_back(w);
            queue_word(w);
        end
        skip_training(w);
        for (m = 0; m < 8; m++) begin
            if (m > 0) begin
                wait_capture(w);
            end
            check_word(w, sent[m], "word before slip");
        end
        @(posedge fabric_clk_div);
        bitslip_n <= 1'b0;                         // One-cycle manual slip
        @(posedge fabric_clk_div);
        bitslip_n <= 1'b1;
        found = 1'b0;
        tries = 0;
        while (!found) begin
            if (tries >= 3) begin
                abort_run("No slipped word appeared within three captures after bitslip");
            end
            wait_capture(w);
            if (w == slipped_word(sent[m], sent[m + 1])) begin
                found = 1'b1;
            end else begin
                check_word(w, sent[m], "word in flight during slip");
                m++;
            end
            check_bit(ready, 1'b1, "ready across slip");
            tries++;
        end
        for (i = m + 1; i < 39; i++) begin
            wait_capture(w);
            check_word(w, slipped_word(sent[i], sent[i + 1]), "slipped word");
            check_bit(ready, 1'b1, "ready after slip");
        end
    endtask

    task automatic test_disable_relock();
        int i;
        int waited;
        @(posedge fabric_clk_div);
        enable_n <= 1'b1;
        repeat (2) @(negedge fabric_clk_div);      // Last beat may still strobe
        for (i = 0; i < 18; i++) begin
            @(negedge fabric_clk_div);
            check_bit(ready, 1'b0, "ready while disabled");
            check_bit(data_strobe, 1'b0, "data_strobe while disabled");
        end
        @(negedge fabric_clk_div);
        queue_junk(5);                             // New boundary offset
        @(posedge fabric_clk_div);
        enable_n <= 1'b0;
        wait_ready(lock_limit, waited);            // Settle already done, lock only
        check_bit(waited >= lock_matches * width, 1'b1,
                  "ready held off for the training matches");
        test_payload_in_order();
    endtask

    //******************************
    // Main sequence
    //******************************

    initial begin
        reset_buf_n = 1'b0;
        enable_n    = 1'b0;
        serial_in   = 1'b0;
        bitslip_n   = 1'b1;
        stream_on   = 1'b0;
        rng_state   = 32'h17b;
        fork
            drive_serial();
            watch_strobes();
        join_none
        test_reset_idle();
        test_lock_with_offset();
        test_payload_in_order();
        test_manual_bitslip();
        test_disable_relock();
        $display("Test completed successfully");
        $finish;
    end

endmodule : tb_serial_rx

//--- verilog.f
hdl/rx_pkg.sv
hdl/serial_deserializer.sv
hdl/word_aligner.sv
hdl/rx_word_capture.sv
hdl/serial_rx_top.sv
test/tb_serial_rx.sv

//--- Makefile
# Verilator build and run for the serial receive testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_serial_rx
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test completed successfully

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
